//--- vc_router.f
noc_flit_pkg.sv
vc_router_pkg.sv
vc_input_port.sv
vc_sa_local.sv
vc_sa_global.sv
vc_lookahead_route.sv
vc_output_credits.sv
vc_switch_traversal.sv
vc_router.sv
tb_vc_router.sv

//--- Makefile
# Verilator build and run of the router testbench

TOP := tb_vc_router

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): vc_router.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vc_router.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tb_vc_router.sv
/*
 * testbench for the virtual-channel router
 * credit-keeping senders, credit-returning sinks, scoreboard and watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vc_router import noc_flit_pkg::*, vc_router_pkg::*; ();

  localparam int VCDepth  = 2;
  localparam int NumFlits = 3 + 8 + 24 + 90;
  localparam int W = 0;
  localparam int E = 1;
  localparam int L = 2;

  logic                   clk_i;
  logic                   rst_i;
  coord_t                 xy_id_i;
  logic [NumPorts-1:0]    data_v_i;
  flit_t [NumPorts-1:0]   data_i;
  logic [NumPorts-1:0]    credit_v_o;
  vc_id_t [NumPorts-1:0]  credit_id_o;
  logic [NumPorts-1:0]    data_v_o;
  flit_t [NumPorts-1:0]   data_o;
  logic [NumPorts-1:0]    credit_v_i;
  vc_id_t [NumPorts-1:0]  credit_id_i;

  int seed = 32'hce6f3e0c;
  int errors;
  int sent;
  int received;
  int cyc;
  int east_cnt;
  logic check_lat;
  logic fair_on;
  int last_src;
  int run_len;
  logic [NumPorts-1:0] hold;
  logic [NumPorts-1:0] inc_prev;
  vc_id_t [NumPorts-1:0] inc_id_prev;
  payload_t next_payload;

  // flits waiting to be sent on each input
  flit_t tx_q [NumPorts][$];
  // expected flits and their sampling edge per (input, vc, output)
  flit_t sb_q [NumPorts][NumVC][NumPorts][$];
  int    edge_q [NumPorts][NumVC][NumPorts][$];
  // credits the sinks still owe per output
  vc_id_t ret_q [NumPorts][$];
  // sender copy of the router input credits
  int mirror [NumPorts][NumVC];
  // copy of the router output credit counters
  int model [NumPorts][NumVC];

  vc_router #(
    .VCDepth (VCDepth)
  ) dut_i (
    .clk_i, .rst_i, .xy_id_i,
    .data_v_i, .data_i, .credit_v_o, .credit_id_o,
    .data_v_o, .data_o, .credit_v_i, .credit_id_i
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // ======================================================================
  // stimulus drivers
  // ======================================================================

  // senders push only on a vc they hold credit for
  initial begin
    int v;
    flit_t f;
    forever begin
      @(posedge clk_i);
      #1;
      for (int i = 0; i < NumPorts; i++) begin
        data_v_i[i] = 1'b0;
        v = $random(seed) & 1;
        if (mirror[i][v] == 0) v = 1 - v;
        if (!rst_i && tx_q[i].size() > 0 && mirror[i][v] > 0) begin
          f = tx_q[i].pop_front();
          f[FlitVcLsb +: VcIdW] = vc_id_t'(v);
          mirror[i][v]--;
          data_v_i[i] = 1'b1;
          data_i[i] = f;
          sb_q[i][v][f[FlitRouteLsb +: RouteW]].push_back(f);
          edge_q[i][v][f[FlitRouteLsb +: RouteW]].push_back(cyc + 1);
          sent++;
        end
      end
    end
  end

  // sinks hand credits back after a random delay
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      for (int o = 0; o < NumPorts; o++) begin
        credit_v_i[o] = 1'b0;
        if (!hold[o] && ret_q[o].size() > 0 && ($random(seed) & 3) != 0) begin
          credit_v_i[o] = 1'b1;
          credit_id_i[o] = ret_q[o].pop_front();
        end
      end
    end
  end

  // ======================================================================
  // checks sampled mid-cycle where all outputs are stable
  // ======================================================================

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (data_v_o == '0 && credit_v_o == '0))
    else begin
      errors++;
      $display("[ERROR] data_v_o/credit_v_o after reset: %h/%h", data_v_o, credit_v_o);
    end

  always @(negedge clk_i) begin
    logic [NumPorts-1:0] exp_cr;
    vc_id_t [NumPorts-1:0] exp_id;
    flit_t f;
    int hit;
    int lowest;
    route_dir_e nd;
    exp_cr = '0;
    exp_id = '0;
    if (!rst_i) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (data_v_o[o]) begin
          f = data_o[o];
          received++;
          hit = -1;
          for (int i = 0; i < NumPorts; i++) begin
            for (int v = 0; v < NumVC; v++) begin
              if (hit < 0 && sb_q[i][v][o].size() > 0 &&
                  sb_q[i][v][o][0][15:0] == f[15:0]) begin
                hit = i * NumVC + v;
              end
            end
          end
          assert (hit >= 0) else begin
            errors++;
            $display("unexpected or reordered flit on output %0d, payload %h", o, f[15:0]);
          end
          if (hit >= 0) begin
            exp_cr[hit / NumVC] = 1'b1;
            exp_id[hit / NumVC] = vc_id_t'(hit % NumVC);
            if (check_lat) begin
              assert (cyc == edge_q[hit / NumVC][hit % NumVC][o][0] + 1) else begin
                errors++;
                $display("flit %h left late on output %0d", f[15:0], o);
              end
            end
            void'(edge_q[hit / NumVC][hit % NumVC][o].pop_front());
            assert (f[FlitDstLsb +: CoordW] ==
                    sb_q[hit / NumVC][hit % NumVC][o][0][FlitDstLsb +: CoordW])
            else begin
              errors++;
              $display("[ERROR] data_o[%0d] dst exp %h got %h", o,
                sb_q[hit / NumVC][hit % NumVC][o][0][FlitDstLsb +: CoordW],
                f[FlitDstLsb +: CoordW]);
            end
            void'(sb_q[hit / NumVC][hit % NumVC][o].pop_front());
          end
          // the next node ejects the flit when it is the destination
          if (o == E) begin
            nd = (f[FlitDstLsb +: CoordW] == xy_id_i + 4'd1) ? DirLocal : DirEast;
          end else if (o == W) begin
            nd = (f[FlitDstLsb +: CoordW] == xy_id_i - 4'd1) ? DirLocal : DirWest;
          end else begin
            nd = DirLocal;
          end
          assert (f[FlitRouteLsb +: RouteW] == nd) else begin
            errors++;
            $display("[ERROR] data_o[%0d] route exp %h got %h", o, nd,
              f[FlitRouteLsb +: RouteW]);
          end
          lowest = (model[o][0] > 0) ? 0 : 1;
          assert (f[FlitVcLsb] == lowest[0] && model[o][lowest] > 0) else begin
            errors++;
            $display("[ERROR] data_o[%0d] vc exp %h got %h", o, lowest, f[FlitVcLsb]);
          end
          model[o][f[FlitVcLsb]]--;
          ret_q[o].push_back(f[FlitVcLsb]);
          if (o == E) begin
            east_cnt++;
            run_len = (hit / NumVC == last_src) ? run_len + 1 : 1;
            last_src = hit / NumVC;
            if (fair_on && tx_q[W].size() > 0 && tx_q[L].size() > 0) begin
              assert (run_len <= 2) else begin
                errors++;
                $display("input %0d won output east %0d times in a row", last_src, run_len);
              end
            end
          end
        end
      end
      // credit returns towards the senders
      for (int i = 0; i < NumPorts; i++) begin
        assert (credit_v_o[i] == exp_cr[i]) else begin
          errors++;
          $display("[ERROR] credit_v_o[%0d] exp %h got %h", i, exp_cr[i], credit_v_o[i]);
        end
        if (credit_v_o[i] && exp_cr[i]) begin
          assert (credit_id_o[i] == exp_id[i]) else begin
            errors++;
            $display("[ERROR] credit_id_o[%0d] exp %h got %h", i, exp_id[i], credit_id_o[i]);
          end
        end
        if (credit_v_o[i]) mirror[i][credit_id_o[i]]++;
        if (inc_prev[i]) model[i][inc_id_prev[i]]++;
      end
      inc_prev = credit_v_i;
      inc_id_prev = credit_id_i;
    end
  end

  // ======================================================================
  // test sequence
  // ======================================================================

  // queue one flit with a fresh payload on an input
  task automatic queue_flit(input int in_port, input int out_port, input coord_t dst);
    flit_t f;
    f = '0;
    f[FlitPayloadLsb +: PayloadW] = next_payload;
    f[FlitDstLsb +: CoordW] = dst;
    f[FlitRouteLsb +: RouteW] = RouteW'(out_port);
    next_payload++;
    tx_q[in_port].push_back(f);
  endtask

  task automatic wait_drained();
    int n;
    int busy;
    n = 0;
    busy = 1;
    while (busy != 0 && n < 2000) begin
      @(posedge clk_i);
      n++;
      busy = 0;
      for (int i = 0; i < NumPorts; i++) begin
        busy += tx_q[i].size();
        for (int v = 0; v < NumVC; v++)
          for (int o = 0; o < NumPorts; o++) busy += sb_q[i][v][o].size();
      end
    end
    assert (busy == 0) else begin
      errors++;
      $display("flits still missing after 2000 cycles");
    end
  endtask

  initial begin
    int o;
    rst_i = 1'b1;
    xy_id_i = 4'd5;
    data_v_i = '0;
    data_i = '0;
    credit_v_i = '0;
    credit_id_i = '0;
    errors = 0;
    sent = 0;
    received = 0;
    cyc = 0;
    east_cnt = 0;
    check_lat = 1'b0;
    fair_on = 1'b0;
    last_src = -1;
    run_len = 0;
    hold = '0;
    inc_prev = '0;
    inc_id_prev = '0;
    next_payload = 16'h0100;
    for (int i = 0; i < NumPorts; i++)
      for (int v = 0; v < NumVC; v++) begin
        mirror[i][v] = VCDepth;
        model[i][v] = VCDepth;
      end
    repeat (2) @(posedge clk_i);
    #1 rst_i = 1'b0;
    repeat (3) @(posedge clk_i);

    // one lone flit per input with exact latency
    check_lat = 1'b1;
    queue_flit(W, E, 4'd6);
    wait_drained();
    queue_flit(E, L, 4'd5);
    wait_drained();
    queue_flit(L, W, 4'd1);
    wait_drained();
    check_lat = 1'b0;

    // east sink stalls so at most NumVC * VCDepth flits get through
    hold[E] = 1'b1;
    east_cnt = 0;
    for (int k = 0; k < 4; k++) begin
      queue_flit(W, E, 4'd9);
      queue_flit(L, E, 4'd6);
    end
    repeat (60) @(posedge clk_i);
    assert (east_cnt <= NumVC * VCDepth) else begin
      errors++;
      $display("%0d flits left east without credit", east_cnt);
    end
    hold[E] = 1'b0;
    wait_drained();

    // two inputs compete for east
    last_src = -1;
    run_len = 0;
    fair_on = 1'b1;
    for (int k = 0; k < 12; k++) begin
      queue_flit(W, E, 4'd12);
      queue_flit(L, E, 4'd7);
    end
    wait_drained();
    fair_on = 1'b0;

    // random traffic from every input
    for (int k = 0; k < 30; k++) begin
      for (int i = 0; i < NumPorts; i++) begin
        o = (i + 1 + ($random(seed) & 1)) % NumPorts;
        queue_flit(i, o, coord_t'($random(seed)));
      end
    end
    wait_drained();
    repeat (5) @(posedge clk_i);

    $display("errors: %0d, sent: %0d, received: %0d", errors, sent, received);
    if (errors == 0 && sent == received) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the flit count
  initial begin
    #((NumFlits * 20 + 200) * 40);
    $display("timeout: the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- vc_router.sv
/*
 * virtual-channel router for a 1-d chain
 * three ports, two vcs each, credit flow control and look-ahead routing
 */

`timescale 1ns/1ps
`default_nettype none

module vc_router import noc_flit_pkg::*, vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  coord_t                      xy_id_i,
  // upstream side, indexed by route_dir_e
  input  wire  [NumPorts-1:0]         data_v_i,
  input  flit_t [NumPorts-1:0]        data_i,
  output logic [NumPorts-1:0]         credit_v_o,
  output vc_id_t [NumPorts-1:0]       credit_id_o,
  // downstream side
  output logic [NumPorts-1:0]         data_v_o,
  output flit_t [NumPorts-1:0]        data_o,
  input  wire  [NumPorts-1:0]         credit_v_i,
  input  vc_id_t [NumPorts-1:0]       credit_id_i
);

  // ======================================================================
  // signals crossing between inputs and outputs
  // ======================================================================

  // local winner of each input
  port_oh_t                   req_v;
  vc_id_t     [NumPorts-1:0]  req_vc;
  route_dir_e [NumPorts-1:0]  req_dir;
  flit_t      [NumPorts-1:0]  req_flit;
  // grant of each output, one bit per input
  port_oh_t   [NumPorts-1:0]  grant;

  for (genvar g = 0; g < NumPorts; g++) begin : gen_port
    vc_oh_t             head_v;
    flit_t [NumVC-1:0]  head;
    logic               pop;
    logic               st_v;
    logic               free_v;
    vc_id_t             out_vc;
    flit_t              sel_flit;
    route_dir_e         next_dir;

    // input side: this input was granted by some output
    always_comb begin
      pop = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        pop = pop | grant[o][g];
      end
    end

    vc_input_port #(
      .VCDepth      (VCDepth)
    ) i_input_port (
      .clk_i, .rst_i,
      .data_v_i     (data_v_i[g]),
      .data_i       (data_i[g]),
      .credit_v_o   (credit_v_o[g]),
      .credit_id_o  (credit_id_o[g]),
      .head_v_o     (head_v),
      .head_o       (head),
      .pop_i        (pop),
      .pop_vc_i     (req_vc[g])
    );

    vc_sa_local i_sa_local (
      .clk_i, .rst_i,
      .my_dir_i     (route_dir_e'(g)),
      .head_v_i     (head_v),
      .head_i       (head),
      .granted_i    (pop),
      .req_v_o      (req_v[g]),
      .req_vc_o     (req_vc[g]),
      .req_dir_o    (req_dir[g]),
      .req_flit_o   (req_flit[g])
    );

    // output side
    vc_sa_global i_sa_global (
      .clk_i, .rst_i,
      .my_dir_i     (route_dir_e'(g)),
      .req_v_i      (req_v),
      .req_dir_i    (req_dir),
      .free_v_i     (free_v),
      .grant_oh_o   (grant[g])
    );

    assign st_v = |grant[g];

    // flit of the granted input
    always_comb begin
      sel_flit = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (grant[g][i]) begin
          sel_flit = req_flit[i];
        end
      end
    end

    vc_output_credits #(
      .VCDepth      (VCDepth)
    ) i_output_credits (
      .clk_i, .rst_i,
      .credit_v_i   (credit_v_i[g]),
      .credit_id_i  (credit_id_i[g]),
      .assign_i     (st_v),
      .free_v_o     (free_v),
      .out_vc_o     (out_vc)
    );

    // the granted head leaves through this port, so its route is g
    vc_lookahead_route i_lookahead_route (
      .dir_i        (route_dir_e'(g)),
      .dst_i        (coord_t'(sel_flit[FlitDstLsb +: CoordW])),
      .xy_id_i      (xy_id_i),
      .next_dir_o   (next_dir)
    );

    vc_switch_traversal i_switch_traversal (
      .clk_i, .rst_i,
      .st_v_i       (st_v),
      .flit_i       (sel_flit),
      .out_vc_i     (out_vc),
      .next_dir_i   (next_dir),
      .data_v_o     (data_v_o[g]),
      .data_o       (data_o[g])
    );
  end

endmodule

`default_nettype wire

//--- vc_switch_traversal.sv
/*
 * switch traversal
 * SA-to-ST register with header rewrite for the next hop
 */

`timescale 1ns/1ps
`default_nettype none

module vc_switch_traversal import noc_flit_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         st_v_i,
  input  flit_t       flit_i,
  input  vc_id_t      out_vc_i,
  input  route_dir_e  next_dir_i,
  output logic        data_v_o,
  output flit_t       data_o
);

  // flit as it leaves, payload and dst untouched
  flit_t out_flit;

  always_comb begin
    out_flit                              = flit_i;
    // downstream vc picked from the credit counters
    out_flit[FlitVcLsb +: VcIdW]          = out_vc_i;
    // look-ahead route for the next node
    out_flit[FlitRouteLsb +: RouteW]      = next_dir_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= st_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_v_i) begin
      data_o <= out_flit;
    end
  end

endmodule

`default_nettype wire

//--- vc_output_credits.sv
/*
 * output credit tracking
 * downstream credit counters per vc and lowest-free vc selection
 */

`timescale 1ns/1ps
`default_nettype none

module vc_output_credits import noc_flit_pkg::*, vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  wire       clk_i,
  input  wire       rst_i,
  // credit pulses from the downstream router
  input  wire       credit_v_i,
  input  vc_id_t    credit_id_i,
  // a flit is sent this cycle on out_vc_o
  input  wire       assign_i,
  output logic      free_v_o,
  output vc_id_t    out_vc_o
);

  // vcs that have at least one credit
  vc_oh_t free_vc;

  // ======================================================================
  // vc selection
  // ======================================================================

  // lowest index wins, scan from the top down
  always_comb begin
    out_vc_o = '0;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (free_vc[v]) begin
        out_vc_o = vc_id_t'(v);
      end
    end
  end

  assign free_v_o = |free_vc;

  // ======================================================================
  // counters
  // ======================================================================

  for (genvar v = 0; v < NumVC; v++) begin : gen_cnt
    credit_cnt_t cnt;
    logic        dec;
    logic        inc;

    assign dec = assign_i && (out_vc_o == vc_id_t'(v));
    assign inc = credit_v_i && (credit_id_i == vc_id_t'(v));

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        // downstream buffers start empty
        cnt <= credit_cnt_t'(VCDepth);
      end else begin
        cnt <= cnt - credit_cnt_t'(dec) + credit_cnt_t'(inc);
      end
    end

    assign free_vc[v] = (cnt != '0);

    // a grant to this output is only legal with a credit in hand
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      dec |-> (cnt != '0))
      else $error("credit underflow on vc %0d", v);

    // downstream returns no more credits than it has slots
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      cnt <= credit_cnt_t'(VCDepth))
      else $error("credit overflow on vc %0d: %h", v, cnt);
  end

endmodule

`default_nettype wire

//--- vc_lookahead_route.sv
/*
 * look-ahead routing
 * direction the flit takes at the next node of the chain
 */

`timescale 1ns/1ps
`default_nettype none

module vc_lookahead_route import noc_flit_pkg::*; (
  input  route_dir_e  dir_i,
  input  coord_t      dst_i,
  input  coord_t      xy_id_i,
  output route_dir_e  next_dir_o
);

  // neighbours along the chain
  coord_t east_nb;
  coord_t west_nb;

  assign east_nb = xy_id_i + coord_t'(1);
  assign west_nb = xy_id_i - coord_t'(1);

  always_comb begin
    case (dir_i)
      // keep going east unless the next node is the target
      DirEast: next_dir_o = (dst_i == east_nb) ? DirLocal : DirEast;
      // mirrored for west
      DirWest: next_dir_o = (dst_i == west_nb) ? DirLocal : DirWest;
      // ejected here, field is don't-care for the local sink
      default: next_dir_o = DirLocal;
    endcase
  end

endmodule

`default_nettype wire

//--- vc_sa_global.sv
/*
 * global switch allocation
 * round-robin grant of one output among the requesting inputs
 */

`timescale 1ns/1ps
`default_nettype none

module vc_sa_global import noc_flit_pkg::*, vc_router_pkg::*; (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  route_dir_e                  my_dir_i,
  input  port_oh_t                    req_v_i,
  input  route_dir_e [NumPorts-1:0]   req_dir_i,
  input  wire                         free_v_i,
  output port_oh_t                    grant_oh_o
);

  // input with the highest priority, 0..NumPorts-1
  logic [1:0] rr_ptr;
  logic [1:0] winner;
  port_oh_t   req_here;

  // inputs whose local winner wants this output
  for (genvar i = 0; i < NumPorts; i++) begin : gen_match
    assign req_here[i] = req_v_i[i] && (req_dir_i[i] == my_dir_i);
  end

  // no downstream credit on any vc means no grant at all
  always_comb begin
    int idx;
    grant_oh_o = '0;
    winner     = rr_ptr;
    for (int k = 0; k < NumPorts; k++) begin
      idx = (int'(rr_ptr) + k) % NumPorts;
      if (free_v_i && (grant_oh_o == '0) && req_here[idx]) begin
        grant_oh_o[idx] = 1'b1;
        winner          = 2'(idx);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr <= '0;
    end else if (grant_oh_o != '0) begin
      // next round starts after the winner
      rr_ptr <= (winner == 2'(NumPorts - 1)) ? 2'd0 : winner + 2'd1;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant_oh_o))
    else $error("output %0d grant not one-hot: %h", my_dir_i, grant_oh_o);

endmodule

`default_nettype wire

//--- vc_sa_local.sv
/*
 * local switch allocation
 * round-robin pick of one vc with a valid head per input
 */

`timescale 1ns/1ps
`default_nettype none

module vc_sa_local import noc_flit_pkg::*, vc_router_pkg::*; (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  route_dir_e              my_dir_i,
  input  vc_oh_t                  head_v_i,
  input  flit_t [NumVC-1:0]       head_i,
  input  wire                     granted_i,
  output logic                    req_v_o,
  output vc_id_t                  req_vc_o,
  output route_dir_e              req_dir_o,
  output flit_t                   req_flit_o
);

  // vc with the highest priority this cycle
  vc_id_t rr_ptr;

  // first valid head at or after the pointer
  always_comb begin
    vc_id_t cand;
    req_v_o  = 1'b0;
    req_vc_o = rr_ptr;
    for (int k = 0; k < NumVC; k++) begin
      // wraps through the vc_id width
      cand = rr_ptr + vc_id_t'(k);
      if (!req_v_o && head_v_i[cand]) begin
        req_v_o  = 1'b1;
        req_vc_o = cand;
      end
    end
  end

  assign req_flit_o = head_i[req_vc_o];
  // route field already names the exit of this router
  assign req_dir_o  = route_dir_e'(req_flit_o[FlitRouteLsb +: RouteW]);

  // pointer moves past the winner only when the flit really left
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr <= '0;
    end else if (granted_i) begin
      rr_ptr <= req_vc_o + 1'b1;
    end
  end

  // no u-turn: a flit never asks for the port it came in on
  a_no_uturn: assert property (@(posedge clk_i) disable iff (rst_i)
    req_v_o |-> (req_dir_o != my_dir_i))
    else $error("u-turn request on port %0d", my_dir_i);

endmodule

`default_nettype wire

//--- vc_input_port.sv
/*
 * input port
 * one circular FIFO per virtual channel, head exposure and credit return
 */

`timescale 1ns/1ps
`default_nettype none

module vc_input_port import noc_flit_pkg::*, vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  wire                     clk_i,
  input  wire                     rst_i,
  // upstream link
  input  wire                     data_v_i,
  input  flit_t                   data_i,
  output logic                    credit_v_o,
  output vc_id_t                  credit_id_o,
  // heads towards local arbitration
  output vc_oh_t                  head_v_o,
  output flit_t [NumVC-1:0]       head_o,
  // pop from the global grant
  input  wire                     pop_i,
  input  vc_id_t                  pop_vc_i
);

  localparam int PtrW = (VCDepth > 1) ? $clog2(VCDepth) : 1;

  // vc of the incoming flit, taken from its header
  vc_id_t push_vc;

  assign push_vc = vc_id_t'(data_i[FlitVcLsb +: VcIdW]);

  // advance a FIFO pointer with wrap at the depth
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(VCDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ======================================================================
  // per-vc FIFOs
  // ======================================================================

  for (genvar v = 0; v < NumVC; v++) begin : gen_vc
    flit_t           mem [VCDepth];
    logic [PtrW-1:0] rd_ptr;
    logic [PtrW-1:0] wr_ptr;
    credit_cnt_t     count;
    logic            push;
    logic            pop;

    assign push = data_v_i && (push_vc == vc_id_t'(v));
    assign pop  = pop_i && (pop_vc_i == vc_id_t'(v));

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop) begin
          rd_ptr <= next_ptr(rd_ptr);
        end
        // push and pop in one cycle leave the count unchanged
        count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
      end
    end

    // storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr] <= data_i;
      end
    end

    // head is visible the cycle after its write
    assign head_v_o[v] = (count != '0);
    assign head_o[v]   = mem[rd_ptr];

    // sender must hold credit, so a full vc never sees a push
    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
      push |-> (count != credit_cnt_t'(VCDepth)))
      else $error("push into full vc %0d", v);

    // grants only come from a valid head
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      pop |-> (count != '0))
      else $error("pop from empty vc %0d", v);
  end

  // ======================================================================
  // credit return
  // ======================================================================

  // one pulse per popped flit, the cycle after the pop
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_o <= pop_vc_i;
  end

endmodule

`default_nettype wire

//--- vc_router_pkg.sv
/*
 * router internals
 * port and vc counts, one-hot vectors and credit counter type
 */

`default_nettype none

package vc_router_pkg;

  // west, east, local
  localparam int NumPorts = 3;
  // one vc per value of the vc_id field
  localparam int NumVC    = 2 ** $bits(noc_flit_pkg::vc_id_t);

  // one bit per port, used for input sets and grants
  typedef logic [NumPorts-1:0] port_oh_t;

  // one bit per virtual channel
  typedef logic [NumVC-1:0]    vc_oh_t;

  // holds 0..VCDepth, enough for a depth up to 3
  typedef logic [1:0]          credit_cnt_t;

endpackage

`default_nettype wire

//--- noc_flit_pkg.sv
/*
 * noc flit format
 * link-level field widths, direction encoding and bit offsets of a flit
 */

`default_nettype none

package noc_flit_pkg;

  // field widths
  localparam int PayloadW = 16;
  localparam int CoordW   = 4;
  localparam int VcIdW    = 1;
  localparam int RouteW   = 2;
  localparam int FlitW    = PayloadW + CoordW + VcIdW + RouteW;

  // output direction, also used to index the router ports
  typedef enum logic [RouteW-1:0] {
    DirWest  = 2'd0,
    DirEast  = 2'd1,
    DirLocal = 2'd2
  } route_dir_e;

  typedef logic [CoordW-1:0]   coord_t;
  typedef logic [VcIdW-1:0]    vc_id_t;
  typedef logic [PayloadW-1:0] payload_t;

  // flit layout, lsb first: payload, dst_x, vc_id, route
  typedef logic [FlitW-1:0]    flit_t;

  localparam int FlitPayloadLsb = 0;
  localparam int FlitDstLsb     = FlitPayloadLsb + PayloadW;
  localparam int FlitVcLsb      = FlitDstLsb + CoordW;
  localparam int FlitRouteLsb   = FlitVcLsb + VcIdW;

endpackage

`default_nettype wire
